// File: Makefile
# Verilator build and run for the PWM subsystem testbench

TOP       ?= pwm_subsystem_tb
FILELIST  ?= pwm_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: pwm_subsystem.f
rtl/bus_pkg.sv
rtl/pwm_pkg.sv
rtl/bus_fsm.sv
rtl/pwm_fsm.sv
rtl/h_bridge.sv
rtl/pwm_channel.sv
rtl/pwm_subsystem.sv
tb/pwm_subsystem_tb.sv

// File: rtl/bus_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module bus_fsm
   import pwm_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic subsystem_enable,
   input  logic handshake_1,
   input  logic rw,
   output logic handshake_2,
   output logic read_word_from_bus,
   output logic write_data_word_to_bus
);

   bus_state_t state;

   // request seen in idle, strobe one cycle later, data settles,
   // then handshake_2 goes up and stays until the host lets go
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= BUS_IDLE;
         handshake_2 <= 1'b0;
         read_word_from_bus <= 1'b0;
         write_data_word_to_bus <= 1'b0;
      end else begin
         // strobes are single cycle pulses
         read_word_from_bus <= 1'b0;
         write_data_word_to_bus <= 1'b0;
         // ack follows release state by one cycle, both on the way up and down
         handshake_2 <= (state == BUS_RELEASE);
         case (state)
            BUS_IDLE: begin
               // only answer when our address range is on the bus
               if (subsystem_enable && handshake_1) begin
                  state <= BUS_ACCESS;
               end
            end
            BUS_ACCESS: begin
               // rw high, host writes so we take the word from the bus
               read_word_from_bus <= rw;
               // rw low, host reads so we put a word on the bus
               write_data_word_to_bus <= !rw;
               state <= BUS_ACKNOWLEDGE;
            end
            BUS_ACKNOWLEDGE: begin
               // channel registers load on the strobe here
               state <= BUS_RELEASE;
            end
            BUS_RELEASE: begin
               // host drops handshake_1 once it has seen the ack
               if (!handshake_1) begin
                  state <= BUS_IDLE;
               end
            end
            default: begin
               state <= BUS_IDLE;
            end
         endcase
      end
   end

   // a single access is either a write or a read, never both
   strobes_exclusive: assert property (
      @(posedge clk) disable iff (!reset)
      !(read_word_from_bus && write_data_word_to_bus)
   );

endmodule

`default_nettype wire

// File: rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

   // internal register bus, 32-bit data and 8-bit register address
   localparam int BUS_WIDTH = 32;
   localparam int ADDR_WIDTH = 8;

   // one register or data word on the bus
   typedef logic [BUS_WIDTH-1:0] bus_word_t;

   // register address as seen on reg_address
   typedef logic [ADDR_WIDTH-1:0] reg_addr_t;

   // first address of the PWM block
   // channel n starts at PWM_BASE + n * NOS_PWM_REGISTERS
   localparam reg_addr_t PWM_BASE = 8'h20;

   // registers per channel
   localparam int NOS_PWM_REGISTERS = 4;

   // register offsets within a channel
   // period and on-time are in clock cycles
   localparam reg_addr_t PWM_PERIOD = 8'd0;
   localparam reg_addr_t PWM_ON_TIME = 8'd1;
   localparam reg_addr_t PWM_CONFIG = 8'd2;
   // status is read only, writes to it are dropped
   localparam reg_addr_t PWM_STATUS = 8'd3;

endpackage

`default_nettype wire

// File: rtl/h_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module h_bridge
   import pwm_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic pwm,
   input  logic enable,
   input  h_bridge_cmd_t command,
   input  logic swap,
   input  invert_t invert,
   output logic h_bridge_1,
   output logic h_bridge_2
);

   // command decode stage
   logic pin_1_drive;
   logic pin_2_drive;
   // after swap
   logic pin_1_swapped;
   logic pin_2_swapped;
   // after invert
   logic pin_1_inv;
   logic pin_2_inv;

   always_comb begin
      case (command)
         CMD_FORWARD: begin
            pin_1_drive = pwm;
            pin_2_drive = 1'b0;
         end
         CMD_REVERSE: begin
            pin_1_drive = 1'b0;
            pin_2_drive = pwm;
         end
         CMD_BRAKE: begin
            // both low-side paths on, motor shorted
            pin_1_drive = 1'b1;
            pin_2_drive = 1'b1;
         end
         default: begin
            // coast, bridge off
            pin_1_drive = 1'b0;
            pin_2_drive = 1'b0;
         end
      endcase
   end

   // swap lets the motor leads be wired either way round
   assign pin_1_swapped = swap ? pin_2_drive : pin_1_drive;
   assign pin_2_swapped = swap ? pin_1_drive : pin_2_drive;

   // per pin polarity for active-low gate drivers
   assign pin_1_inv = pin_1_swapped ^ invert[0];
   assign pin_2_inv = pin_2_swapped ^ invert[1];

   // one cycle latency from pwm to the pins
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         h_bridge_1 <= 1'b0;
         h_bridge_2 <= 1'b0;
      end else begin
         h_bridge_1 <= enable && pin_1_inv;
         h_bridge_2 <= enable && pin_2_inv;
      end
   end

   // both pins high only on purpose: brake, or a flipped polarity
   no_shoot_through: assert property (
      @(posedge clk) disable iff (!reset)
      (pin_1_inv && pin_2_inv) |-> ((command == CMD_BRAKE) || (invert != '0))
   );

endmodule

`default_nettype wire

// File: rtl/pwm_channel.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_channel
   import bus_pkg::*;
   import pwm_pkg::*;
#(
   parameter int pwm_unit = 0
) (
   input  logic clk,
   input  logic reset,
   input  logic handshake_1,
   input  logic rw,
   input  reg_addr_t reg_address,
   input  logic register_address_valid,
   input  bus_word_t bus_wdata,
   output bus_word_t bus_rdata,
   output logic selected,
   output logic handshake_2,
   output logic pwm_signal,
   output logic h_bridge_1,
   output logic h_bridge_2
);

   // this channel's four-register window
   localparam reg_addr_t FIRST_REG = reg_addr_t'(PWM_BASE + pwm_unit * NOS_PWM_REGISTERS);
   localparam reg_addr_t LAST_REG = reg_addr_t'(FIRST_REG + PWM_STATUS);

   // registers as seen from the bus
   bus_word_t t_period;
   bus_word_t t_on;
   bus_word_t pwm_config;
   bus_word_t pwm_status;

   // working down-counters
   bus_word_t t_period_count;
   bus_word_t t_on_count;

   // offset of the current access within the window
   reg_addr_t reg_offset;

   logic subsystem_enable;
   logic read_word_from_bus;
   logic write_data_word_to_bus;

   logic pwm_enable;
   logic t_on_zero;
   logic t_period_zero;
   logic dec_t_on;
   logic dec_t_period;
   logic reload_times;
   logic pwm;

   // config fields for the bridge
   logic h_bridge_enable;
   h_bridge_cmd_t h_bridge_cmd;
   logic h_bridge_swap;
   invert_t h_bridge_invert;

   bus_fsm bus_fsm_inst (
      .clk                    (clk),
      .reset                  (reset),
      .subsystem_enable       (subsystem_enable),
      .handshake_1            (handshake_1),
      .rw                     (rw),
      .handshake_2            (handshake_2),
      .read_word_from_bus     (read_word_from_bus),
      .write_data_word_to_bus (write_data_word_to_bus)
   );

   pwm_fsm pwm_fsm_inst (
      .clk           (clk),
      .reset         (reset),
      .pwm_enable    (pwm_enable),
      .t_on_zero     (t_on_zero),
      .t_period_zero (t_period_zero),
      .dec_t_on      (dec_t_on),
      .dec_t_period  (dec_t_period),
      .reload_times  (reload_times),
      .pwm           (pwm)
   );

   h_bridge h_bridge_inst (
      .clk        (clk),
      .reset      (reset),
      .pwm        (pwm),
      .enable     (h_bridge_enable),
      .command    (h_bridge_cmd),
      .swap       (h_bridge_swap),
      .invert     (h_bridge_invert),
      .h_bridge_1 (h_bridge_1),
      .h_bridge_2 (h_bridge_2)
   );

   // address decode, qualified by the host's valid flag
   always_comb begin
      subsystem_enable = 1'b0;
      if (register_address_valid) begin
         if ((reg_address >= FIRST_REG) && (reg_address <= LAST_REG)) begin
            subsystem_enable = 1'b1;
         end
      end
   end

   assign selected = subsystem_enable;
   assign reg_offset = reg_address - FIRST_REG;

   // host writes, strobe only comes while we are addressed
   // any new timing value stops the output until it is re-enabled
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         t_period <= '0;
         t_on <= '0;
         pwm_config <= '0;
      end else if (read_word_from_bus) begin
         case (reg_offset)
            PWM_PERIOD: begin
               t_period <= bus_wdata - T_PERIOD_ADJUSTMENT;
               pwm_config[PWM_ENABLE] <= 1'b0;
            end
            PWM_ON_TIME: begin
               t_on <= bus_wdata - T_ON_ADJUSTMENT;
               pwm_config[PWM_ENABLE] <= 1'b0;
            end
            PWM_CONFIG: begin
               pwm_config <= bus_wdata;
            end
            default: begin
               // status is read only
               pwm_config <= pwm_config;
            end
         endcase
      end
   end

   // host reads, word is held until the next read
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         bus_rdata <= '0;
      end else if (write_data_word_to_bus) begin
         case (reg_offset)
            PWM_PERIOD: bus_rdata <= t_period;
            PWM_ON_TIME: bus_rdata <= t_on;
            PWM_CONFIG: bus_rdata <= pwm_config;
            default: bus_rdata <= pwm_status;
         endcase
      end
   end

   // reload takes the stored times, otherwise count down on request
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         t_on_count <= '0;
         t_period_count <= '0;
      end else begin
         if (reload_times) begin
            t_on_count <= t_on;
         end else if (dec_t_on) begin
            t_on_count <= t_on_count - 1'b1;
         end
         if (reload_times) begin
            t_period_count <= t_period;
         end else if (dec_t_period) begin
            t_period_count <= t_period_count - 1'b1;
         end
      end
   end

   assign t_on_zero = (t_on_count == '0);
   assign t_period_zero = (t_period_count == '0);

   // config decode
   assign pwm_enable = pwm_config[PWM_ENABLE];
   assign h_bridge_enable = pwm_config[H_BRIDGE_ENABLE];
   assign h_bridge_cmd = h_bridge_cmd_t'(pwm_config[H_BRIDGE_COMMAND +: H_BRIDGE_CMD_WIDTH]);
   assign h_bridge_swap = pwm_config[H_BRIDGE_SWAP];
   assign h_bridge_invert = pwm_config[H_BRIDGE_INVERT_PINS +: INVERT_WIDTH];

   // live level on top, low half of config below
   assign pwm_status = {pwm, 15'b0, pwm_config[15:0]};

   assign pwm_signal = pwm;

endmodule

`default_nettype wire

// File: rtl/pwm_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_fsm
   import pwm_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic pwm_enable,
   input  logic t_on_zero,
   input  logic t_period_zero,
   output logic dec_t_on,
   output logic dec_t_period,
   output logic reload_times,
   output logic pwm
);

   pwm_state_t state;
   pwm_state_t next_state;

   // on lasts stored t_on + 1 cycles, off runs the period counter down
   // to zero, then reload and straight back to on
   // stored t_on must be below stored t_period for the off phase to exist
   always_comb begin
      next_state = state;
      dec_t_on = 1'b0;
      dec_t_period = 1'b0;
      reload_times = 1'b0;
      case (state)
         PWM_IDLE: begin
            if (pwm_enable) begin
               next_state = PWM_RELOAD;
            end
         end
         PWM_RELOAD: begin
            // first load after enable, output still low
            reload_times = 1'b1;
            next_state = PWM_ON;
         end
         PWM_ON: begin
            // both counters run while high
            dec_t_on = !t_on_zero;
            dec_t_period = !t_period_zero;
            if (t_on_zero) begin
               next_state = PWM_OFF;
            end
         end
         PWM_OFF: begin
            dec_t_period = !t_period_zero;
            if (t_period_zero) begin
               // reload on the way back to on, no extra low cycle
               reload_times = 1'b1;
               next_state = PWM_ON;
            end
         end
         default: begin
            next_state = PWM_IDLE;
         end
      endcase
      // disable wins from any state
      if (!pwm_enable) begin
         next_state = PWM_IDLE;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state <= PWM_IDLE;
      end else begin
         state <= next_state;
      end
   end

   // output level straight from the state register
   assign pwm = (state == PWM_ON);

   // on-time counter only moves in the high phase
   dec_t_on_in_on: assert property (
      @(posedge clk) disable iff (!reset)
      dec_t_on |-> (state == PWM_ON)
   );

endmodule

`default_nettype wire

// File: rtl/pwm_pkg.sv
`default_nettype none

package pwm_pkg;

   // number of PWM channels in the subsystem
   localparam int NUM_PWM_CHANNELS = 2;

   // config register bit positions
   localparam int PWM_ENABLE = 0;
   localparam int H_BRIDGE_ENABLE = 1;
   // lsb of the 2-bit bridge command field
   localparam int H_BRIDGE_COMMAND = 4;
   localparam int H_BRIDGE_SWAP = 8;
   // lsb of the 2-bit pin invert field
   localparam int H_BRIDGE_INVERT_PINS = 12;

   // field widths inside config
   localparam int H_BRIDGE_CMD_WIDTH = 2;
   localparam int INVERT_WIDTH = 2;

   // bridge command, as stored in config[5:4]
   typedef enum logic [H_BRIDGE_CMD_WIDTH-1:0] {
      CMD_COAST = 2'd0,
      CMD_FORWARD = 2'd1,
      CMD_REVERSE = 2'd2,
      CMD_BRAKE = 2'd3
   } h_bridge_cmd_t;

   // bit 0 flips pin 1, bit 1 flips pin 2
   typedef logic [INVERT_WIDTH-1:0] invert_t;

   // peripheral side of the bus handshake
   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_ACCESS,
      BUS_ACKNOWLEDGE,
      BUS_RELEASE
   } bus_state_t;

   // pwm on/off sequencing
   typedef enum logic [1:0] {
      PWM_IDLE,
      PWM_RELOAD,
      PWM_ON,
      PWM_OFF
   } pwm_state_t;

   // taken off the written times so the waveform is exact
   // on state lasts stored value + 1 cycles
   localparam logic [31:0] T_ON_ADJUSTMENT = 32'd1;
   // on plus off lasts stored period + 1 cycles
   localparam logic [31:0] T_PERIOD_ADJUSTMENT = 32'd1;

endpackage

`default_nettype wire

// File: rtl/pwm_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_subsystem
   import bus_pkg::*;
   import pwm_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic handshake_1,
   input  logic rw,
   input  reg_addr_t reg_address,
   input  logic register_address_valid,
   input  bus_word_t bus_wdata,
   output logic handshake_2,
   output bus_word_t bus_rdata,
   output logic [NUM_PWM_CHANNELS-1:0] pwm_signal,
   output logic [NUM_PWM_CHANNELS-1:0] h_bridge_1,
   output logic [NUM_PWM_CHANNELS-1:0] h_bridge_2
);

   // per channel bus returns
   bus_word_t ch_rdata [NUM_PWM_CHANNELS];
   logic [NUM_PWM_CHANNELS-1:0] ch_selected;
   logic [NUM_PWM_CHANNELS-1:0] ch_handshake_2;

   for (genvar i = 0; i < NUM_PWM_CHANNELS; i++) begin : g_channel
      pwm_channel #(
         .pwm_unit (i)
      ) pwm_channel_inst (
         .clk                    (clk),
         .reset                  (reset),
         .handshake_1            (handshake_1),
         .rw                     (rw),
         .reg_address            (reg_address),
         .register_address_valid (register_address_valid),
         .bus_wdata              (bus_wdata),
         .bus_rdata              (ch_rdata[i]),
         .selected               (ch_selected[i]),
         .handshake_2            (ch_handshake_2[i]),
         .pwm_signal             (pwm_signal[i]),
         .h_bridge_1             (h_bridge_1[i]),
         .h_bridge_2             (h_bridge_2[i])
      );
   end

   // only the addressed channel ever acks
   assign handshake_2 = |ch_handshake_2;

   // read data from whichever channel owns the address
   always_comb begin
      bus_rdata = '0;
      for (int i = 0; i < NUM_PWM_CHANNELS; i++) begin
         if (ch_selected[i]) begin
            bus_rdata = ch_rdata[i];
         end
      end
   end

   // the OR above relies on a single channel acking at a time
   one_channel_acks: assert property (
      @(posedge clk) disable iff (!reset)
      $onehot0(ch_handshake_2)
   );

endmodule

`default_nettype wire

// File: tb/pwm_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pwm_subsystem_tb
   import bus_pkg::*;
   import pwm_pkg::*;
();

   localparam int CLK_PERIOD = 100;
   // longest period the random tests pick
   localparam int MAX_PERIOD = 32;
   // limits for the two handshake waits
   localparam int ACK_LIMIT = 10;
   localparam int RELEASE_LIMIT = 10;
   // out-of-range access must stay unanswered this long
   localparam int NO_ACK_WINDOW = 20;
   localparam int ACCESS_CYCLES = 12;
   localparam int BRIDGE_WATCH = 10;
   localparam int STATUS_READS = 6;

   // cycle budget per test, summed into the run limit
   localparam int T1_CYCLES = NUM_PWM_CHANNELS * 6 * ACCESS_CYCLES;
   localparam int T2_CYCLES = NUM_PWM_CHANNELS * (6 * ACCESS_CYCLES + 2 * MAX_PERIOD);
   localparam int T3_CYCLES = NUM_PWM_CHANNELS * (3 * ACCESS_CYCLES + 6 * (MAX_PERIOD + 2));
   localparam int T4_CYCLES = NUM_PWM_CHANNELS * (64 * (ACCESS_CYCLES + BRIDGE_WATCH)
                              + 2 * ACCESS_CYCLES);
   localparam int T5_CYCLES = NUM_PWM_CHANNELS * STATUS_READS * (ACCESS_CYCLES + 8);
   localparam int T6_CYCLES = 2 * (NO_ACK_WINDOW + 4);
   localparam int CYCLE_LIMIT = 8 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                + T5_CYCLES + T6_CYCLES + 200;

   logic clk;
   logic reset;
   logic handshake_1;
   logic rw;
   reg_addr_t reg_address;
   logic register_address_valid;
   bus_word_t bus_wdata;
   logic handshake_2;
   bus_word_t bus_rdata;
   logic [NUM_PWM_CHANNELS-1:0] pwm_signal;
   logic [NUM_PWM_CHANNELS-1:0] h_bridge_1;
   logic [NUM_PWM_CHANNELS-1:0] h_bridge_2;

   // last values the host wrote, per channel
   bus_word_t written_period [NUM_PWM_CHANNELS];
   bus_word_t written_on [NUM_PWM_CHANNELS];
   bus_word_t written_config [NUM_PWM_CHANNELS];

   bus_word_t lcg_state;
   int cycle_count;
   int error_count;
   logic bridge_check_on;
   // pwm level one falling edge back, for the bridge check
   logic [NUM_PWM_CHANNELS-1:0] pwm_prev;
   // pwm level when the read data register loaded
   logic [NUM_PWM_CHANNELS-1:0] pwm_at_load;

   pwm_subsystem pwm_subsystem_inst (
      .clk                    (clk),
      .reset                  (reset),
      .handshake_1            (handshake_1),
      .rw                     (rw),
      .reg_address            (reg_address),
      .register_address_valid (register_address_valid),
      .bus_wdata              (bus_wdata),
      .handshake_2            (handshake_2),
      .bus_rdata              (bus_rdata),
      .pwm_signal             (pwm_signal),
      .h_bridge_1             (h_bridge_1),
      .h_bridge_2             (h_bridge_2)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
         $display("** FAIL **");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   function automatic bus_word_t lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // value in 0 .. n-1, low bits of the lcg are weak
   function automatic bus_word_t rand_below(bus_word_t n);
      return (lcg_next() >> 8) % n;
   endfunction

   function automatic reg_addr_t reg_addr_of(int ch, reg_addr_t offset);
      return reg_addr_t'(PWM_BASE + ch * NOS_PWM_REGISTERS + offset);
   endfunction

   // readback rule: times come back minus their adjustment,
   // status is live level on bit 31 over the low half of config
   function automatic bus_word_t expected_word(int ch, reg_addr_t offset, logic level);
      case (offset)
         PWM_PERIOD: return written_period[ch] - T_PERIOD_ADJUSTMENT;
         PWM_ON_TIME: return written_on[ch] - T_ON_ADJUSTMENT;
         PWM_CONFIG: return written_config[ch];
         default: return {level, 15'b0, written_config[ch][15:0]};
      endcase
   endfunction

   // bridge decode, bit 0 is pin 1 and bit 1 is pin 2
   function automatic logic [1:0] expected_pins(logic level, bus_word_t cfg);
      h_bridge_cmd_t cmd;
      logic [1:0] drive;
      logic [1:0] pins;
      cmd = h_bridge_cmd_t'(cfg[H_BRIDGE_COMMAND +: H_BRIDGE_CMD_WIDTH]);
      case (cmd)
         CMD_FORWARD: drive = {1'b0, level};
         CMD_REVERSE: drive = {level, 1'b0};
         CMD_BRAKE: drive = 2'b11;
         default: drive = 2'b00;
      endcase
      if (cfg[H_BRIDGE_SWAP]) begin
         pins = {drive[0], drive[1]};
      end else begin
         pins = drive;
      end
      pins = pins ^ cfg[H_BRIDGE_INVERT_PINS +: INVERT_WIDTH];
      // bridge off forces both pins low
      if (!cfg[H_BRIDGE_ENABLE]) begin
         pins = 2'b00;
      end
      return pins;
   endfunction

   task automatic end_run_failed();
      error_count++;
      $display("** FAIL **");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_word(string name, bus_word_t got, bus_word_t expected);
      if (got !== expected) begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
         end_run_failed();
      end
   endtask

   task automatic check_bit(string name, logic got, logic expected);
      if (got !== expected) begin
         $display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
         end_run_failed();
      end
   endtask

   // one host access, starts and ends on a falling edge
   task automatic bus_access(input reg_addr_t addr, input logic write,
                             input bus_word_t wdata, output bus_word_t rdata);
      int waited;
      logic [NUM_PWM_CHANNELS-1:0] level_d0;
      logic [NUM_PWM_CHANNELS-1:0] level_d1;
      logic [NUM_PWM_CHANNELS-1:0] level_d2;
      level_d0 = '0;
      level_d1 = '0;
      level_d2 = '0;
      @(negedge clk);
      reg_address = addr;
      rw = write;
      bus_wdata = wdata;
      register_address_valid = 1'b1;
      @(negedge clk);
      handshake_1 = 1'b1;
      waited = 0;
      while (handshake_2 !== 1'b1) begin
         if (waited == ACK_LIMIT) begin
            $display("no handshake_2 within %0d cycles for address 0x%h", ACK_LIMIT, addr);
            end_run_failed();
         end
         @(negedge clk);
         level_d2 = level_d1;
         level_d1 = level_d0;
         level_d0 = pwm_signal;
         waited++;
      end
      rdata = bus_rdata;
      // data register loaded on the strobe, two falling edges before the ack shows
      pwm_at_load = level_d2;
      handshake_1 = 1'b0;
      waited = 0;
      while (handshake_2 !== 1'b0) begin
         if (waited == RELEASE_LIMIT) begin
            $display("handshake_2 still high %0d cycles after release", RELEASE_LIMIT);
            end_run_failed();
         end
         @(negedge clk);
         waited++;
      end
      register_address_valid = 1'b0;
   endtask

   // write, then track the register model
   task automatic bus_write(int ch, reg_addr_t offset, bus_word_t data);
      bus_word_t unused_rdata;
      bus_access(reg_addr_of(ch, offset), 1'b1, data, unused_rdata);
      case (offset)
         PWM_PERIOD: begin
            written_period[ch] = data;
            written_config[ch][PWM_ENABLE] = 1'b0;
         end
         PWM_ON_TIME: begin
            written_on[ch] = data;
            written_config[ch][PWM_ENABLE] = 1'b0;
         end
         PWM_CONFIG: begin
            written_config[ch] = data;
         end
      endcase
   endtask

   task automatic bus_read(int ch, reg_addr_t offset, output bus_word_t data);
      bus_access(reg_addr_of(ch, offset), 1'b0, '0, data);
   endtask

   task automatic read_and_check(int ch, reg_addr_t offset);
      bus_word_t data;
      bus_read(ch, offset, data);
      check_word($sformatf("bus_rdata ch%0d reg %0d", ch, offset), data,
                 expected_word(ch, offset, pwm_at_load[ch]));
   endtask

   // steps falling edges until the pwm level is reached, returns the count
   task automatic wait_level(int ch, logic level, output int cycles);
      cycles = 0;
      while (pwm_signal[ch] !== level) begin
         @(negedge clk);
         cycles++;
         if (cycles > MAX_PERIOD + 2) begin
            $display("pwm_signal[%0d] did not reach %b in time", ch, level);
            end_run_failed();
         end
      end
   endtask

   // random times with on below period, config last so enable sticks
   task automatic load_random_times(int ch);
      bus_word_t period;
      bus_word_t on_time;
      period = 32'd4 + rand_below(bus_word_t'(MAX_PERIOD - 3));
      on_time = 32'd1 + rand_below(period - 32'd1);
      bus_write(ch, PWM_PERIOD, period);
      bus_write(ch, PWM_ON_TIME, on_time);
   endtask

   // pins against the decode of the level one cycle back
   always @(negedge clk) begin
      logic [1:0] pins;
      if (bridge_check_on) begin
         for (int ch = 0; ch < NUM_PWM_CHANNELS; ch++) begin
            pins = expected_pins(pwm_prev[ch], written_config[ch]);
            check_bit($sformatf("h_bridge_1[%0d]", ch), h_bridge_1[ch], pins[0]);
            check_bit($sformatf("h_bridge_2[%0d]", ch), h_bridge_2[ch], pins[1]);
         end
      end
      pwm_prev = pwm_signal;
   end

   initial begin
      int high_cycles;
      int low_cycles;
      bus_word_t cfg;
      clk = 1'b0;
      reset = 1'b0;
      handshake_1 = 1'b0;
      rw = 1'b0;
      reg_address = '0;
      register_address_valid = 1'b0;
      bus_wdata = '0;
      lcg_state = 32'h4ad0;
      cycle_count = 0;
      error_count = 0;
      bridge_check_on = 1'b0;
      pwm_prev = '0;
      pwm_at_load = '0;
      for (int ch = 0; ch < NUM_PWM_CHANNELS; ch++) begin
         written_period[ch] = '0;
         written_on[ch] = '0;
         written_config[ch] = '0;
      end
      repeat (3) @(negedge clk);
      reset = 1'b1;
      @(negedge clk);
      check_bit("handshake_2", handshake_2, 1'b0);
      check_word("pwm_signal", bus_word_t'(pwm_signal), '0);
      check_word("h_bridge_1", bus_word_t'(h_bridge_1), '0);
      check_word("h_bridge_2", bus_word_t'(h_bridge_2), '0);

      // register readback, both channels written before either is read
      for (int ch = 0; ch < NUM_PWM_CHANNELS; ch++) begin
         load_random_times(ch);
         bus_write(ch, PWM_CONFIG, lcg_next());
      end
      for (int ch = 0; ch < NUM_PWM_CHANNELS; ch++) begin
         read_and_check(ch, PWM_PERIOD);
         read_and_check(ch, PWM_ON_TIME);
         read_and_check(ch, PWM_CONFIG);
      end

      // a new time drops the enable bit and stops the output
      for (int ch = 0; ch < NUM_PWM_CHANNELS; ch++) begin
         bus_write(ch, PWM_CONFIG, written_config[ch] | 32'h1);
         bus_write(ch, PWM_PERIOD, written_period[ch]);
         read_and_check(ch, PWM_CONFIG);
         repeat (MAX_PERIOD) begin
            @(negedge clk);
            check_bit($sformatf("pwm_signal[%0d]", ch), pwm_signal[ch], 1'b0);
         end
         bus_write(ch, PWM_CONFIG, written_config[ch] | 32'h1);
         bus_write(ch, PWM_ON_TIME, written_on[ch]);
         read_and_check(ch, PWM_CONFIG);
         repeat (MAX_PERIOD) begin
            @(negedge clk);
            check_bit($sformatf("pwm_signal[%0d]", ch), pwm_signal[ch], 1'b0);
         end
      end

      // waveform timing over three periods back to back
      for (int ch = 0; ch < NUM_PWM_CHANNELS; ch++) begin
         load_random_times(ch);
         bus_write(ch, PWM_CONFIG, lcg_next() | 32'h1);
         wait_level(ch, 1'b0, low_cycles);
         wait_level(ch, 1'b1, low_cycles);
         repeat (3) begin
            wait_level(ch, 1'b0, high_cycles);
            wait_level(ch, 1'b1, low_cycles);
            check_word($sformatf("pwm high time ch%0d", ch),
                       bus_word_t'(high_cycles), written_on[ch]);
            check_word($sformatf("pwm period ch%0d", ch),
                       bus_word_t'(high_cycles + low_cycles), written_period[ch]);
         end
      end

      // every bridge setting, short period so both levels show up
      for (int ch = 0; ch < NUM_PWM_CHANNELS; ch++) begin
         bus_write(ch, PWM_PERIOD, 32'd5);
         bus_write(ch, PWM_ON_TIME, 32'd2);
         for (int combo = 0; combo < 64; combo++) begin
            cfg = 32'h1;
            cfg[H_BRIDGE_ENABLE] = combo[5];
            cfg[H_BRIDGE_COMMAND +: H_BRIDGE_CMD_WIDTH] = combo[1:0];
            cfg[H_BRIDGE_SWAP] = combo[2];
            cfg[H_BRIDGE_INVERT_PINS +: INVERT_WIDTH] = combo[4:3];
            bus_write(ch, PWM_CONFIG, cfg);
            bridge_check_on = 1'b1;
            repeat (BRIDGE_WATCH) @(negedge clk);
            bridge_check_on = 1'b0;
         end
      end

      // status reads land at random points of the running waveform
      for (int ch = 0; ch < NUM_PWM_CHANNELS; ch++) begin
         repeat (STATUS_READS) begin
            repeat (rand_below(32'd7)) @(negedge clk);
            read_and_check(ch, PWM_STATUS);
         end
      end

      // below and above the PWM window, nobody answers
      for (int k = 0; k < 2; k++) begin
         @(negedge clk);
         reg_address = (k == 0) ? reg_addr_t'(PWM_BASE - 1)
                                : reg_addr_of(NUM_PWM_CHANNELS, PWM_PERIOD);
         rw = 1'b0;
         register_address_valid = 1'b1;
         @(negedge clk);
         handshake_1 = 1'b1;
         repeat (NO_ACK_WINDOW) begin
            @(negedge clk);
            if (handshake_2 !== 1'b0) begin
               $display("access to unmapped address 0x%h got handshake_2", reg_address);
               end_run_failed();
            end
         end
         handshake_1 = 1'b0;
         register_address_valid = 1'b0;
      end

      @(negedge clk);
      if (error_count == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire
